//--- Makefile
# Verilator build and run for the MIPS decode stage

TOP = decodeStageTb
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ns \
		-f flist.f --top-module $(TOP) -Mdir obj_dir -o simv

run: compile
	./obj_dir/simv | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- bench/decodeStageTb.sv
`default_nettype none
`timescale 1ns/1ns

module decodeStageTb;

	import mipsPkg::*;

	localparam int resetCycles = 3;
	localparam int sweepCycles = 32;
	localparam int directedCycles = 6;
	localparam int randomCycles = 2000;
	localparam int testCycles = 2 * (resetCycles + sweepCycles) + directedCycles + randomCycles;
	localparam int timeoutNs = (testCycles + 100) * 10;

	logic clk = 1'b0;
	logic reset;
	logic [dataWidth-1:0] instr;
	logic [dataWidth-1:0] pc4;
	logic wbWrite;
	logic [regAddrWidth-1:0] wbReg;
	logic [dataWidth-1:0] wbData;
	logic [dataWidth-1:0] rsValue;
	logic [dataWidth-1:0] rtValue;
	logic [dataWidth-1:0] immExt;
	logic [dataWidth-1:0] npc;
	logic redirect;
	aluOpT aluOp;
	logic regWrite;
	logic [regAddrWidth-1:0] destReg;
	logic memWrite;
	logic memToReg;
	logic illegal;

	// Reference state
	logic [dataWidth-1:0] modelRegs [regCount];
	int errorCount;
	int checkCount;

	// Expected outputs for the instruction in decode
	logic expRegWrite;
	logic expMemWrite;
	logic expMemToReg;
	logic expIllegal;
	logic [regAddrWidth-1:0] expDest;
	aluOpT expAlu;
	logic aluKnown;
	logic [dataWidth-1:0] expImm;
	logic immKnown;
	logic [dataWidth-1:0] expNpc;
	logic expRedirect;

	decodeStage dut (
		.clk(clk), .reset(reset), .instr(instr), .pc4(pc4), .wbWrite(wbWrite),
		.wbReg(wbReg), .wbData(wbData), .rsValue(rsValue), .rtValue(rtValue),
		.immExt(immExt), .npc(npc), .redirect(redirect), .aluOp(aluOp),
		.regWrite(regWrite), .destReg(destReg), .memWrite(memWrite),
		.memToReg(memToReg), .illegal(illegal)
	);

	always #5 clk = ~clk;

	//////////////////////////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////////////////////////

	task automatic computeExpected(input logic [31:0] ins, input logic [31:0] pcPlus4);
		logic [5:0] op;
		logic [5:0] fn;
		logic [15:0] imm;
		logic [31:0] pcNow;
		logic [31:0] rsModel;
		logic [31:0] rtModel;
		op = ins[31:26];
		fn = ins[5:0];
		imm = ins[15:0];
		pcNow = pcPlus4 - 32'd4;
		rsModel = modelRegs[ins[25:21]];
		rtModel = modelRegs[ins[20:16]];
		expRegWrite = 1'b0;
		expMemWrite = 1'b0;
		expMemToReg = 1'b0;
		expIllegal = 1'b0;
		expDest = '0;
		expAlu = aluAdd;
		aluKnown = 1'b0;
		expImm = '0;
		immKnown = 1'b0;
		expNpc = pcPlus4;
		expRedirect = 1'b0;
		case (op)
			opSpecial: begin
				if (fn == functAddu || fn == functSubu) begin
					expRegWrite = 1'b1;
					expDest = ins[15:11];
					expAlu = (fn == functAddu) ? aluAdd : aluSub;
					aluKnown = 1'b1;
				end else if (fn == functJr) begin
					expNpc = rsModel;
					expRedirect = 1'b1;
				end else begin
					expIllegal = 1'b1;
				end
			end
			opOri: begin
				expRegWrite = 1'b1;
				expDest = ins[20:16];
				expAlu = aluOr;
				aluKnown = 1'b1;
				expImm = {16'h0000, imm};
				immKnown = 1'b1;
			end
			opLui: begin
				expRegWrite = 1'b1;
				expDest = ins[20:16];
				expAlu = aluPassB;
				aluKnown = 1'b1;
				expImm = {imm, 16'h0000};
				immKnown = 1'b1;
			end
			opLw, opSw: begin
				expRegWrite = (op == opLw);
				expMemWrite = (op == opSw);
				expMemToReg = (op == opLw);
				expDest = ins[20:16];
				expAlu = aluAdd;
				aluKnown = 1'b1;
				expImm = {{16{imm[15]}}, imm};
				immKnown = 1'b1;
			end
			opBeq: begin
				expImm = {{16{imm[15]}}, imm};
				immKnown = 1'b1;
				if (rsModel == rtModel) begin
					expNpc = pcPlus4 + (expImm << 2);
					expRedirect = 1'b1;
				end
			end
			opJ, opJal: begin
				expNpc = (pcNow & 32'hf000_0000) | (32'(ins[25:0]) << 2);
				expRedirect = 1'b1;
				if (op == opJal) begin
					expRegWrite = 1'b1;
					expDest = linkReg;
					expAlu = aluPassB;
					aluKnown = 1'b1;
				end
			end
			default: expIllegal = 1'b1;
		endcase
	endtask

	//////////////////////////////////////////////////////////////////////
	// Checking and stimulus helpers
	//////////////////////////////////////////////////////////////////////

	task automatic checkField(input string name, input logic [31:0] got, input logic [31:0] want);
		checkCount++;
		assert (got === want) else begin
			errorCount++;
			$display("FAILED at %0t: %s is %h, expected %h", $time, name, got, want);
		end
	endtask

	task automatic checkOutputs();
		computeExpected(instr, pc4);
		checkField("rsValue", rsValue, modelRegs[instr[25:21]]);
		checkField("rtValue", rtValue, modelRegs[instr[20:16]]);
		checkField("regWrite", 32'(regWrite), 32'(expRegWrite));
		checkField("memWrite", 32'(memWrite), 32'(expMemWrite));
		checkField("memToReg", 32'(memToReg), 32'(expMemToReg));
		checkField("illegal", 32'(illegal), 32'(expIllegal));
		checkField("npc", npc, expNpc);
		checkField("redirect", 32'(redirect), 32'(expRedirect));
		// destReg only matters when a register is written
		if (expRegWrite) checkField("destReg", 32'(destReg), 32'(expDest));
		if (aluKnown) checkField("aluOp", 32'(aluOp), 32'(expAlu));
		if (immKnown) checkField("immExt", immExt, expImm);
	endtask

	// Drive on the falling edge, check just before the rising edge
	task automatic applyCycle(input logic [31:0] newInstr, input logic [31:0] newPc4,
		input logic doWrite, input logic [4:0] writeReg, input logic [31:0] writeData);
		@(negedge clk);
		instr = newInstr;
		pc4 = newPc4;
		wbWrite = doWrite;
		wbReg = writeReg;
		wbData = writeData;
		#4;
		checkOutputs();
		if (doWrite && writeReg != 5'd0) modelRegs[writeReg] = writeData;
	endtask

	// Every register read through rs and rt, instr zero first
	task automatic sweepRegisters();
		for (int i = 0; i < sweepCycles; i++) begin
			applyCycle({6'b000000, 5'(i), 5'(i), 16'h0000}, 32'h0000_0004, 1'b0, 5'd0, 32'h0);
		end
	endtask

	function automatic logic isSupportedOp(input logic [5:0] op);
		return op inside {opSpecial, opJ, opJal, opBeq, opOri, opLui, opLw, opSw};
	endfunction

	function automatic logic [31:0] randomInstr();
		logic [31:0] ins;
		logic [5:0] code;
		int kind;
		ins = $urandom;
		kind = int'($urandom % 12);
		case (kind)
			0: ins = {opSpecial, ins[25:6], functAddu};
			1: ins = {opSpecial, ins[25:6], functSubu};
			2: ins = {opSpecial, ins[25:6], functJr};
			3: ins[31:26] = opOri;
			4: ins[31:26] = opLui;
			5: ins[31:26] = opLw;
			6: ins[31:26] = opSw;
			7: begin
				ins[31:26] = opBeq;
				// Same register on both sides, always taken
				if ($urandom % 3 == 0) ins[20:16] = ins[25:21];
			end
			8: ins[31:26] = opJ;
			9: ins[31:26] = opJal;
			10: begin
				do code = 6'($urandom % 64); while (isSupportedOp(code));
				ins[31:26] = code;
			end
			default: begin
				do code = 6'($urandom % 64);
				while (code == functAddu || code == functSubu || code == functJr);
				ins = {opSpecial, ins[25:6], code};
			end
		endcase
		return ins;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		logic [31:0] r;
		void'($urandom(32'h08aec79e));
		errorCount = 0;
		checkCount = 0;
		reset = 1'b1;
		instr = '0;
		pc4 = '0;
		wbWrite = 1'b0;
		wbReg = '0;
		wbData = '0;
		for (int i = 0; i < regCount; i++) modelRegs[i] = '0;
		repeat (resetCycles) @(negedge clk);
		reset = 1'b0;

		sweepRegisters();

		// Equal and unequal operands for beq, then a write to zero
		applyCycle(32'h0, 32'h0000_0004, 1'b1, 5'd5, 32'h0000_1234);
		applyCycle(32'h0, 32'h0000_0004, 1'b1, 5'd6, 32'h0000_1234);
		applyCycle(32'h0, 32'h0000_0004, 1'b1, 5'd7, 32'h0000_0055);
		applyCycle({opBeq, 5'd5, 5'd6, 16'hfff0}, 32'h0040_0100, 1'b1, 5'd0, 32'hdead_beef);
		applyCycle({opBeq, 5'd5, 5'd7, 16'h0010}, 32'h0040_0100, 1'b0, 5'd0, 32'h0);
		applyCycle({opSpecial, 5'd0, 5'd0, 16'h0000}, 32'h0040_0104, 1'b0, 5'd0, 32'h0);

		for (int n = 0; n < randomCycles; n++) begin
			r = $urandom;
			// Small data values now and then so beq operands match
			applyCycle(randomInstr(), $urandom & 32'hffff_fffc, r[0], r[5:1],
				r[6] ? $urandom : {30'b0, r[8:7]});
		end

		// Reset again with live contents, every register must clear
		@(negedge clk);
		instr = '0;
		wbWrite = 1'b0;
		reset = 1'b1;
		repeat (resetCycles) @(negedge clk);
		reset = 1'b0;
		for (int i = 0; i < regCount; i++) modelRegs[i] = '0;
		sweepRegisters();

		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#(timeoutNs);
		$display("Timeout: the test sequence did not complete in time");
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- common/mipsPkg.sv
`default_nettype none

package mipsPkg;

	//////////////////////////////////////////////////////////////////////
	// Machine widths
	//////////////////////////////////////////////////////////////////////

	localparam int dataWidth = 32;
	localparam int regAddrWidth = 5;
	localparam int regCount = 32;
	localparam int immWidth = 16;

	// Register that jal links into
	localparam logic [regAddrWidth-1:0] linkReg = 5'd31;

	//////////////////////////////////////////////////////////////////////
	// Instruction encodings
	//////////////////////////////////////////////////////////////////////

	// Primary opcode, instr[31:26]
	typedef enum logic [5:0] {
		opSpecial = 6'b000000,
		opJ       = 6'b000010,
		opJal     = 6'b000011,
		opBeq     = 6'b000100,
		opOri     = 6'b001101,
		opLui     = 6'b001111,
		opLw      = 6'b100011,
		opSw      = 6'b101011
	} opcodeT;

	// Function field of opSpecial, instr[5:0]
	typedef enum logic [5:0] {
		functJr   = 6'b001000,
		functAddu = 6'b100001,
		functSubu = 6'b100011
	} functT;

	//////////////////////////////////////////////////////////////////////
	// Stage controls
	//////////////////////////////////////////////////////////////////////

	// Operation for the execute stage
	typedef enum logic [1:0] {
		aluAdd   = 2'd0,
		aluSub   = 2'd1,
		aluOr    = 2'd2,
		aluPassB = 2'd3
	} aluOpT;

	// Immediate extension mode
	typedef enum logic [1:0] {
		extZero = 2'd0,
		extSign = 2'd1,
		extHigh = 2'd2
	} extOpT;

	// Next-PC source
	typedef enum logic [1:0] {
		npcSeq    = 2'd0,
		npcBranch = 2'd1,
		npcJump   = 2'd2,
		npcReg    = 2'd3
	} npcOpT;

endpackage

`default_nettype wire

//--- flist.f
common/mipsPkg.sv
hw/controlDecoder.sv
hw/regFile.sv
hw/immExtend.sv
hw/nextPcUnit.sv
hw/decodeStage.sv
bench/decodeStageTb.sv

//--- hw/controlDecoder.sv
`default_nettype none
`timescale 1ns/1ns

module controlDecoder (
	input  logic [mipsPkg::dataWidth-1:0]    instr,
	output mipsPkg::aluOpT                   aluOp,
	output mipsPkg::extOpT                   extOp,
	output mipsPkg::npcOpT                   npcOp,
	output logic                             regWrite,
	output logic                             memWrite,
	output logic                             memToReg,
	output logic                             illegal,
	output logic [mipsPkg::regAddrWidth-1:0] destReg
);

	import mipsPkg::*;

	opcodeT opcode;
	functT funct;
	logic [regAddrWidth-1:0] rtField;
	logic [regAddrWidth-1:0] rdField;

	assign opcode = opcodeT'(instr[31:26]);
	assign funct = functT'(instr[5:0]);
	assign rtField = instr[20:16];
	assign rdField = instr[15:11];

	always_comb begin
		// Idle values, nothing written
		aluOp = aluAdd;
		extOp = extZero;
		npcOp = npcSeq;
		regWrite = 1'b0;
		memWrite = 1'b0;
		memToReg = 1'b0;
		illegal = 1'b0;
		destReg = '0;

		case (opcode)
			opSpecial: begin
				case (funct)
					functAddu: begin
						regWrite = 1'b1;
						destReg = rdField;
					end
					functSubu: begin
						aluOp = aluSub;
						regWrite = 1'b1;
						destReg = rdField;
					end
					functJr: npcOp = npcReg;
					default: illegal = 1'b1;
				endcase
			end
			opOri: begin
				aluOp = aluOr;
				regWrite = 1'b1;
				destReg = rtField;
			end
			opLui: begin
				aluOp = aluPassB;
				extOp = extHigh;
				regWrite = 1'b1;
				destReg = rtField;
			end
			opLw: begin
				extOp = extSign;
				regWrite = 1'b1;
				memToReg = 1'b1;
				destReg = rtField;
			end
			opSw: begin
				extOp = extSign;
				memWrite = 1'b1;
			end
			opBeq: begin
				extOp = extSign;
				npcOp = npcBranch;
			end
			opJ: npcOp = npcJump;
			opJal: begin
				// Link value itself comes from write-back
				aluOp = aluPassB;
				npcOp = npcJump;
				regWrite = 1'b1;
				destReg = linkReg;
			end
			default: illegal = 1'b1;
		endcase

		// No instruction both writes a register and stores
		assert (!(regWrite && memWrite))
			else $error("controlDecoder: regWrite and memWrite both set");
	end

endmodule

`default_nettype wire

//--- hw/decodeStage.sv
`default_nettype none
`timescale 1ns/1ns

module decodeStage (
	input  logic                             clk,
	input  logic                             reset,
	input  logic [mipsPkg::dataWidth-1:0]    instr,
	input  logic [mipsPkg::dataWidth-1:0]    pc4,
	input  logic                             wbWrite,
	input  logic [mipsPkg::regAddrWidth-1:0] wbReg,
	input  logic [mipsPkg::dataWidth-1:0]    wbData,
	output logic [mipsPkg::dataWidth-1:0]    rsValue,
	output logic [mipsPkg::dataWidth-1:0]    rtValue,
	output logic [mipsPkg::dataWidth-1:0]    immExt,
	output logic [mipsPkg::dataWidth-1:0]    npc,
	output logic                             redirect,
	output mipsPkg::aluOpT                   aluOp,
	output logic                             regWrite,
	output logic [mipsPkg::regAddrWidth-1:0] destReg,
	output logic                             memWrite,
	output logic                             memToReg,
	output logic                             illegal
);

	import mipsPkg::*;

	// Instruction fields
	logic [regAddrWidth-1:0] rsField;
	logic [regAddrWidth-1:0] rtField;
	logic [immWidth-1:0] immField;

	extOpT extOp;
	npcOpT npcOp;

	assign rsField = instr[25:21];
	assign rtField = instr[20:16];
	assign immField = instr[15:0];

	controlDecoder decoder (
		.instr(instr), .aluOp(aluOp), .extOp(extOp), .npcOp(npcOp),
		.regWrite(regWrite), .memWrite(memWrite), .memToReg(memToReg),
		.illegal(illegal), .destReg(destReg)
	);

	regFile regs (
		.clk(clk), .reset(reset), .rsAddr(rsField), .rtAddr(rtField),
		.wbReg(wbReg), .wbWrite(wbWrite), .wbData(wbData),
		.rsValue(rsValue), .rtValue(rtValue)
	);

	immExtend extender (.imm(immField), .extOp(extOp), .immExt(immExt));

	// Branch compare uses the register file outputs directly
	nextPcUnit nextPc (
		.pc4(pc4), .instr(instr), .npcOp(npcOp), .rsValue(rsValue),
		.rtValue(rtValue), .npc(npc), .redirect(redirect)
	);

endmodule

`default_nettype wire

//--- hw/immExtend.sv
`default_nettype none
`timescale 1ns/1ns

module immExtend (
	input  logic [mipsPkg::immWidth-1:0]  imm,
	input  mipsPkg::extOpT                extOp,
	output logic [mipsPkg::dataWidth-1:0] immExt
);

	import mipsPkg::*;

	localparam int padWidth = dataWidth - immWidth;

	always_comb begin
		case (extOp)
			extSign: begin
				immExt = {{padWidth{imm[immWidth-1]}}, imm};
			end
			extHigh: begin
				// lui places the immediate in the upper half
				immExt = {imm, {padWidth{1'b0}}};
			end
			default: begin
				// extZero
				immExt = {{padWidth{1'b0}}, imm};
			end
		endcase
	end

endmodule

`default_nettype wire

//--- hw/nextPcUnit.sv
`default_nettype none
`timescale 1ns/1ns

module nextPcUnit (
	input  logic [mipsPkg::dataWidth-1:0] pc4,
	input  logic [mipsPkg::dataWidth-1:0] instr,
	input  mipsPkg::npcOpT                npcOp,
	input  logic [mipsPkg::dataWidth-1:0] rsValue,
	input  logic [mipsPkg::dataWidth-1:0] rtValue,
	output logic [mipsPkg::dataWidth-1:0] npc,
	output logic                          redirect
);

	import mipsPkg::*;

	logic operandsEqual;
	logic [dataWidth-1:0] pcCurrent;
	logic [dataWidth-1:0] branchTarget;
	logic [dataWidth-1:0] jumpTarget;

	//////////////////////////////////////////////////////////////////////
	// Targets
	//////////////////////////////////////////////////////////////////////

	// beq comparator
	assign operandsEqual = (rsValue == rtValue);

	// Address of the instruction in decode
	assign pcCurrent = pc4 - 32'd4;

	// Word offset, sign extended and scaled by four
	assign branchTarget = pc4 + {{14{instr[15]}}, instr[15:0], 2'b00};

	// Region bits of the current PC with the 26-bit index
	assign jumpTarget = {pcCurrent[31:28], instr[25:0], 2'b00};

	//////////////////////////////////////////////////////////////////////
	// Selection
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		npc = pc4;
		redirect = 1'b0;

		case (npcOp)
			npcBranch: begin
				if (operandsEqual) begin
					npc = branchTarget;
					redirect = 1'b1;
				end
			end
			npcJump: begin
				npc = jumpTarget;
				redirect = 1'b1;
			end
			npcReg: begin
				npc = rsValue;
				redirect = 1'b1;
			end
			default: ;
		endcase

		// Sequential flow never asks fetch to redirect
		assert (!(npcOp == npcSeq && redirect))
			else $error("nextPcUnit: redirect set on sequential flow");
	end

endmodule

`default_nettype wire

//--- hw/regFile.sv
`default_nettype none
`timescale 1ns/1ns

module regFile (
	input  logic                             clk,
	input  logic                             reset,
	input  logic [mipsPkg::regAddrWidth-1:0] rsAddr,
	input  logic [mipsPkg::regAddrWidth-1:0] rtAddr,
	input  logic [mipsPkg::regAddrWidth-1:0] wbReg,
	input  logic                             wbWrite,
	input  logic [mipsPkg::dataWidth-1:0]    wbData,
	output logic [mipsPkg::dataWidth-1:0]    rsValue,
	output logic [mipsPkg::dataWidth-1:0]    rtValue
);

	import mipsPkg::*;

	logic [dataWidth-1:0] regs [regCount];

	//////////////////////////////////////////////////////////////////////
	// Write port
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < regCount; i++) begin
				regs[i] <= '0;
			end
		end else if (wbWrite && (wbReg != '0)) begin
			// Register zero is never written
			regs[wbReg] <= wbData;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Read ports
	//////////////////////////////////////////////////////////////////////

	// No bypass, a write shows up on the next cycle
	assign rsValue = regs[rsAddr];
	assign rtValue = regs[rtAddr];

	//////////////////////////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////////////////////////

	// Entry zero holds zero from reset on, whatever write-back sends
	zeroRegHeld: assert property (
		@(posedge clk) disable iff (reset)
		regs[0] == '0
	) else $error("regFile: register zero is not zero");

endmodule

`default_nettype wire
